// ==== filelist.f ====
design/disc_pkg.sv
design/disc_cfg_regs.sv
design/disc_trigger_detect.sv
design/disc_gate.sv
design/disc_top.sv
bench/disc_tb.sv

// ==== bench/disc_tb.sv ====
////////////////////////////////////////////////////////////
// directed testbench for the sample discriminator; sets up
// the DUT over AXI4-Lite, plays sample runs and compares the
// gated samples and timestamps with a reference model
////////////////////////////////////////////////////////////
module disc_tb;

  localparam int MAX_REC       = 256;
  localparam int TOTAL_SAMPLES = 730;
  localparam int WATCHDOG_CYC  = TOTAL_SAMPLES * 20 + 2000;

  logic                                 adc_clk;
  logic                                 reset;
  logic                                 state_clear;
  disc_pkg::axil_req_t                  axil_req;
  disc_pkg::axil_rsp_t                  axil_rsp;
  disc_pkg::sample_bus_t                samples_in;
  logic [disc_pkg::DIGITAL_INPUTS-1:0]  dig_in;
  disc_pkg::out_bus_t                   samples_out;
  disc_pkg::tstamp_bus_t                tstamps_out;

  logic [31:0] seed = 32'h66d8;

  // testbench copy of the channel configuration
  logic [disc_pkg::SAMPLE_WIDTH-1:0] cfg_low   [disc_pkg::CHANNELS];
  logic [disc_pkg::SAMPLE_WIDTH-1:0] cfg_high  [disc_pkg::CHANNELS];
  logic [disc_pkg::DELAY_BITS-1:0]   cfg_start [disc_pkg::CHANNELS];
  logic [disc_pkg::DELAY_BITS-1:0]   cfg_stop  [disc_pkg::CHANNELS];
  logic [disc_pkg::SRC_BITS-1:0]     cfg_src   [disc_pkg::CHANNELS];
  logic [disc_pkg::CHANNELS-1:0]     cfg_dis;

  // one run of stimulus, generated before it is played
  logic [disc_pkg::SAMPLE_WIDTH-1:0]   rec_data [disc_pkg::CHANNELS][MAX_REC];
  logic [disc_pkg::DIGITAL_INPUTS-1:0] rec_dig  [MAX_REC];
  int                                  rec_n;
  logic [disc_pkg::SAMPLE_WIDTH-1:0]   exp_smp  [disc_pkg::CHANNELS][$];
  logic [disc_pkg::TSTAMP_WIDTH-1:0]   exp_ts   [disc_pkg::CHANNELS][$];

  disc_top uut (
    .adc_clk        (adc_clk),
    .reset_i        (reset),
    .state_clear_i  (state_clear),
    .axil_req_i     (axil_req),
    .axil_rsp_o     (axil_rsp),
    .samples_i      (samples_in),
    .digital_trig_i (dig_in),
    .samples_o      (samples_out),
    .tstamps_o      (tstamps_out)
  );

  initial adc_clk = 1'b0;
  always #5 adc_clk = ~adc_clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // AXI4-Lite access
  ////////////////////////////////////////////////////////////
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            output disc_pkg::axil_resp_e resp);
    @(posedge adc_clk);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    do @(posedge adc_clk); while (!axil_rsp.awready);
    // address and data are taken on the same cycle
    check_value("wready", 32'(axil_rsp.wready), 32'd1);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    do @(posedge adc_clk); while (!axil_rsp.bvalid);
    resp = axil_rsp.bresp;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output disc_pkg::axil_resp_e resp);
    @(posedge adc_clk);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    do @(posedge adc_clk); while (!axil_rsp.arready);
    axil_req.arvalid <= 1'b0;
    do @(posedge adc_clk); while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
  endtask

  task automatic set_channel(input int c, input logic [15:0] low, input logic [15:0] high,
                             input logic [3:0] start, input logic [3:0] stop);
    disc_pkg::axil_resp_e resp;
    cfg_low[c]   = low;
    cfg_high[c]  = high;
    cfg_start[c] = start;
    cfg_stop[c]  = stop;
    axil_write(c == 0 ? disc_pkg::THRESH0 : disc_pkg::THRESH1, {high, low}, resp);
    check_value("bresp", 32'(resp), 32'(disc_pkg::OKAY));
    axil_write(c == 0 ? disc_pkg::DELAY0 : disc_pkg::DELAY1, {24'h0, stop, start}, resp);
    check_value("bresp", 32'(resp), 32'(disc_pkg::OKAY));
  endtask

  task automatic set_routing(input logic [1:0] src0, input logic [1:0] src1,
                             input logic [1:0] dis);
    disc_pkg::axil_resp_e resp;
    cfg_src[0] = src0;
    cfg_src[1] = src1;
    cfg_dis    = dis;
    axil_write(disc_pkg::SRC, {28'h0, src1, src0}, resp);
    check_value("bresp", 32'(resp), 32'(disc_pkg::OKAY));
    axil_write(disc_pkg::DISABLE, {30'h0, dis}, resp);
    check_value("bresp", 32'(resp), 32'(disc_pkg::OKAY));
  endtask

  ////////////////////////////////////////////////////////////
  // reference model and run playback
  ////////////////////////////////////////////////////////////
  task automatic build_expected();
    logic st [disc_pkg::CHANNELS];
    logic trig [disc_pkg::CHANNELS][MAX_REC];
    logic keep;
    logic prev;
    for (int k = 0; k < disc_pkg::CHANNELS; k++) st[k] = 1'b0;
    for (int n = 0; n < rec_n; n++) begin
      for (int k = 0; k < disc_pkg::CHANNELS; k++) begin
        if ($signed(rec_data[k][n]) > $signed(cfg_high[k])) st[k] = 1'b1;
        else if ($signed(rec_data[k][n]) < $signed(cfg_low[k])) st[k] = 1'b0;
      end
      // codes 0 and 1 are analog channels and 2 and 3 digital inputs
      for (int c = 0; c < disc_pkg::CHANNELS; c++) begin
        trig[c][n] = cfg_src[c][1] ? rec_dig[n][cfg_src[c][0]] : st[cfg_src[c][0]];
      end
    end
    // the last MAX_DELAY samples stay in the delay line
    for (int c = 0; c < disc_pkg::CHANNELS; c++) begin
      prev = 1'b0;
      for (int i = 0; i < rec_n - disc_pkg::MAX_DELAY; i++) begin
        keep = cfg_dis[c];
        for (int j = i - int'(cfg_stop[c]); j <= i + int'(cfg_start[c]); j++) begin
          if (j >= 0 && trig[c][j]) keep = 1'b1;
        end
        if (keep) begin
          exp_smp[c].push_back(rec_data[c][i]);
          if (!cfg_dis[c] && (i == 0 || !prev)) exp_ts[c].push_back(i);
        end
        prev = keep;
      end
    end
  endtask

  function automatic logic queues_pending();
    logic busy;
    busy = 1'b0;
    for (int c = 0; c < disc_pkg::CHANNELS; c++) begin
      busy = busy | (exp_smp[c].size() != 0) | (exp_ts[c].size() != 0);
    end
    return busy;
  endfunction

  // random samples in -4096..4095 with digital pulses at rate/256
  task automatic fill_random(input int n, input int rate0, input int rate1);
    logic [31:0] r;
    rec_n = n;
    for (int i = 0; i < n; i++) begin
      r = lcg_next();
      rec_data[0][i] = 16'(int'(r[28:16]) - 4096);
      rec_data[1][i] = 16'(int'(r[12:0]) - 4096);
      r = lcg_next();
      rec_dig[i][0] = int'(r[15:8]) < rate0;
      rec_dig[i][1] = int'(r[23:16]) < rate1;
    end
  endtask

  task automatic play_and_check();
    int gap;
    build_expected();
    @(posedge adc_clk);
    state_clear <= 1'b1;
    @(posedge adc_clk);
    state_clear <= 1'b0;
    for (int n = 0; n < rec_n; n++) begin
      @(posedge adc_clk);
      samples_in.valid   <= 1'b1;
      samples_in.data[0] <= rec_data[0][n];
      samples_in.data[1] <= rec_data[1][n];
      dig_in             <= rec_dig[n];
      gap = int'((lcg_next() >> 16) % 3);
      repeat (gap) begin
        @(posedge adc_clk);
        samples_in.valid <= 1'b0;
      end
    end
    @(posedge adc_clk);
    samples_in.valid <= 1'b0;
    while (queues_pending()) @(posedge adc_clk);
    repeat (4) @(posedge adc_clk);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////
  task automatic test_registers();
    logic [7:0]  addrs [6];
    logic [31:0] wvals [6];
    logic [31:0] masks [6];
    logic [31:0] rd;
    disc_pkg::axil_resp_e resp;
    addrs = '{disc_pkg::THRESH0, disc_pkg::THRESH1, disc_pkg::DELAY0,
              disc_pkg::DELAY1, disc_pkg::SRC, disc_pkg::DISABLE};
    wvals = '{32'h0BB8_FC18, 32'h1388_F060, 32'hFFFF_FF5A,
              32'hAAAA_AAC3, 32'hFFFF_FFF6, 32'hFFFF_FFFE};
    masks = '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_00FF,
              32'h0000_00FF, 32'h0000_000F, 32'h0000_0003};
    for (int i = 0; i < 6; i++) begin
      axil_write(addrs[i], wvals[i], resp);
      check_value("bresp", 32'(resp), 32'(disc_pkg::OKAY));
    end
    for (int i = 0; i < 6; i++) begin
      axil_read(addrs[i], rd, resp);
      check_value("rdata", rd, wvals[i] & masks[i]);
      check_value("rresp", 32'(resp), 32'(disc_pkg::OKAY));
    end
    // unmapped offset
    axil_write(8'h20, 32'hFFFF_FFFF, resp);
    check_value("bresp", 32'(resp), 32'(disc_pkg::SLVERR));
    axil_read(8'h20, rd, resp);
    check_value("rdata", rd, 32'h0);
    check_value("rresp", 32'(resp), 32'(disc_pkg::SLVERR));
    for (int i = 0; i < 6; i++) begin
      axil_read(addrs[i], rd, resp);
      check_value("rdata", rd, wvals[i] & masks[i]);
    end
  endtask

  task automatic test_disabled();
    set_channel(0, 16'(-100), 16'd100, 4'd3, 4'd2);
    set_channel(1, 16'(-100), 16'd100, 4'd0, 4'd0);
    set_routing(2'd0, 2'd1, 2'b11);
    fill_random(60, 40, 40);
    play_and_check();
  endtask

  task automatic test_hysteresis();
    set_channel(0, 16'(-1000), 16'd2000, 4'd0, 4'd0);
    set_channel(1, 16'(-3000), 16'd500, 4'd0, 4'd0);
    set_routing(2'd0, 2'd0, 2'b00);
    fill_random(200, 0, 0);
    play_and_check();
  endtask

  task automatic test_delays();
    rec_n = 80;
    for (int n = 0; n < rec_n; n++) begin
      rec_data[0][n] = ((n % 40) >= 10 && (n % 40) <= 12) ? 16'd3000 :
                       ((n % 40) == 25) ? 16'd1500 : 16'd0;
      rec_data[1][n] = 16'(n * 3);
      rec_dig[n]     = 2'b00;
    end
    set_routing(2'd0, 2'd0, 2'b00);
    set_channel(0, 16'd100, 16'd1000, 4'd5, 4'd3);
    set_channel(1, 16'd100, 16'd1000, 4'd5, 4'd3);
    play_and_check();
    set_channel(0, 16'd100, 16'd1000, 4'd15, 4'd15);
    set_channel(1, 16'd100, 16'd1000, 4'd15, 4'd15);
    play_and_check();
  endtask

  task automatic test_digital();
    set_channel(0, 16'd0, 16'd0, 4'd2, 4'd4);
    set_channel(1, 16'd0, 16'd0, 4'd6, 4'd1);
    set_routing(2'd2, 2'd3, 2'b00);
    fill_random(150, 20, 12);
    play_and_check();
  endtask

  // the first run ends with both states high and the second starts between thresholds
  task automatic test_state_clear();
    set_channel(0, 16'd100, 16'd1000, 4'd2, 4'd2);
    set_channel(1, 16'd100, 16'd1000, 4'd1, 4'd3);
    set_routing(2'd0, 2'd1, 2'b00);
    rec_n = 80;
    for (int n = 0; n < rec_n; n++) begin
      rec_data[0][n] = (n >= 50) ? 16'd2000 : 16'd0;
      rec_data[1][n] = ((n % 20) < 3 || n >= 70) ? 16'd2000 : 16'(-200);
      rec_dig[n]     = 2'b00;
    end
    play_and_check();
    for (int n = 0; n < rec_n; n++) begin
      rec_data[0][n] = (n >= 30 && n < 34) ? 16'd2000 : 16'd500;
      rec_data[1][n] = (n == 45) ? 16'd2000 : 16'd500;
    end
    play_and_check();
  endtask

  ////////////////////////////////////////////////////////////
  // output monitor and watchdog
  ////////////////////////////////////////////////////////////
  always @(posedge adc_clk) begin
    if (!reset) begin
      for (int c = 0; c < disc_pkg::CHANNELS; c++) begin
        if (samples_out.valid[c]) begin
          if (exp_smp[c].size() == 0) begin
            fail_run($sformatf("unexpected sample on channel %0d", c));
          end else begin
            check_value($sformatf("samples_o.data[%0d]", c), 32'(samples_out.data[c]),
                        32'(exp_smp[c].pop_front()));
          end
        end
        if (tstamps_out.valid[c]) begin
          if (exp_ts[c].size() == 0) begin
            fail_run($sformatf("unexpected timestamp on channel %0d", c));
          end else begin
            check_value($sformatf("tstamps_o.index[%0d]", c), tstamps_out.index[c],
                        exp_ts[c].pop_front());
          end
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYC * 10);
    fail_run($sformatf("timeout after %0d cycles, expected outputs never arrived",
                       WATCHDOG_CYC));
  end

  initial begin
    axil_req        = '0;
    axil_req.bready = 1'b1;
    axil_req.rready = 1'b1;
    samples_in      = '0;
    dig_in          = '0;
    state_clear     = 1'b0;
    reset           = 1'b1;
    repeat (2) @(posedge adc_clk);
    reset <= 1'b0;
    test_registers();
    test_disabled();
    test_hysteresis();
    test_delays();
    test_digital();
    test_state_clear();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== design/disc_top.sv ====
////////////////////////////////////////////////////////////
// sample discriminator top level; configuration over
// AXI4-Lite, samples and timestamps on adc_clk streams
////////////////////////////////////////////////////////////
module disc_top (
  // clock and reset
  input  logic                                adc_clk,
  input  logic                                reset_i,
  input  logic                                state_clear_i,

  // configuration
  input  disc_pkg::axil_req_t                 axil_req_i,
  output disc_pkg::axil_rsp_t                 axil_rsp_o,

  // sample stream in
  input  disc_pkg::sample_bus_t               samples_i,
  input  logic [disc_pkg::DIGITAL_INPUTS-1:0] digital_trig_i,

  // gated samples and timestamps out
  output disc_pkg::out_bus_t                  samples_o,
  output disc_pkg::tstamp_bus_t               tstamps_o
);

  ////////////////////////////////////////////////////////////
  // internal buses
  ////////////////////////////////////////////////////////////
  // register values shared by both datapath stages
  disc_pkg::disc_cfg_t cfg;

  // samples with their selected triggers
  disc_pkg::trig_bus_t trig_bus;

  ////////////////////////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////////////////////////
  disc_cfg_regs cfg_regs_i (
    .adc_clk    (adc_clk),
    .reset_i    (reset_i),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .cfg_o      (cfg)
  );

  ////////////////////////////////////////////////////////////
  // trigger detection
  ////////////////////////////////////////////////////////////
  disc_trigger_detect trigger_detect_i (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .state_clear_i  (state_clear_i),
    .cfg_i          (cfg),
    .samples_i      (samples_i),
    .digital_trig_i (digital_trig_i),
    .trig_o         (trig_bus)
  );

  ////////////////////////////////////////////////////////////
  // window gating and timestamps
  ////////////////////////////////////////////////////////////
  disc_gate gate_i (
    .adc_clk       (adc_clk),
    .reset_i       (reset_i),
    .state_clear_i (state_clear_i),
    .cfg_i         (cfg),
    .trig_i        (trig_bus),
    .samples_o     (samples_o),
    .tstamps_o     (tstamps_o)
  );

endmodule

// ==== design/disc_gate.sv ====
////////////////////////////////////////////////////////////
// delays each channel by MAX_DELAY samples, keeps samples near
// a trigger and emits the sample index where a kept run starts
////////////////////////////////////////////////////////////
module disc_gate (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  input  logic                  state_clear_i,
  input  disc_pkg::disc_cfg_t   cfg_i,
  input  disc_pkg::trig_bus_t   trig_i,
  output disc_pkg::out_bus_t    samples_o,
  output disc_pkg::tstamp_bus_t tstamps_o
);

  localparam int HIST_LEN = 2 * disc_pkg::MAX_DELAY;

  // sample delay line, oldest entry at the top
  logic [disc_pkg::CHANNELS-1:0][disc_pkg::MAX_DELAY-1:0][disc_pkg::SAMPLE_WIDTH-1:0] sd_q;
  // trigger history, with the incoming trigger it spans HIST_LEN samples
  logic [disc_pkg::CHANNELS-1:0][HIST_LEN-2:0]     hist_q;
  logic [disc_pkg::CHANNELS-1:0][HIST_LEN-1:0]     hist_w;
  logic [disc_pkg::DELAY_BITS:0]                   fill_q;
  logic                                            primed;
  logic                                            step;
  logic [disc_pkg::TSTAMP_WIDTH-1:0]               idx_q;
  logic [disc_pkg::CHANNELS-1:0]                   keep;
  logic [disc_pkg::CHANNELS-1:0]                   prev_keep_q;
  logic [disc_pkg::CHANNELS-1:0]                   out_valid_q;
  logic [disc_pkg::CHANNELS-1:0]                   ts_valid_q;
  logic [disc_pkg::CHANNELS-1:0][disc_pkg::SAMPLE_WIDTH-1:0] out_data_q;
  logic [disc_pkg::CHANNELS-1:0][disc_pkg::TSTAMP_WIDTH-1:0] ts_idx_q;

  // the first MAX_DELAY samples after a clear only fill the line
  assign primed = (fill_q == (disc_pkg::DELAY_BITS+1)'(disc_pkg::MAX_DELAY));
  assign step   = trig_i.valid && primed && !state_clear_i;

  ////////////////////////////////////////////////////////////
  // keep decision
  ////////////////////////////////////////////////////////////
  // hist_w[m] is the trigger of sample n-m for incoming sample n,
  // so sample i = n-MAX_DELAY sits at m = MAX_DELAY
  always_comb begin
    int lo;
    int hi;
    for (int c = 0; c < disc_pkg::CHANNELS; c++) begin
      hist_w[c] = {hist_q[c], trig_i.trig[c]};
      lo        = disc_pkg::MAX_DELAY - int'(cfg_i.start_dly[c]);
      hi        = disc_pkg::MAX_DELAY + int'(cfg_i.stop_dly[c]);
      keep[c]   = 1'b0;
      for (int m = 1; m < HIST_LEN; m++) begin
        if (m >= lo && m <= hi) begin
          keep[c] = keep[c] | hist_w[c][m];
        end
      end
      // disabled channels pass everything
      if (cfg_i.disable_ch[c]) begin
        keep[c] = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // control state
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      fill_q      <= '0;
      idx_q       <= '0;
      hist_q      <= '0;
      prev_keep_q <= '0;
      out_valid_q <= '0;
      ts_valid_q  <= '0;
    end else begin
      out_valid_q <= step ? keep : '0;
      ts_valid_q  <= step ? (keep & ~prev_keep_q & ~cfg_i.disable_ch) : '0;
      if (state_clear_i) begin
        fill_q      <= '0;
        idx_q       <= '0;
        hist_q      <= '0;
        prev_keep_q <= '0;
      end else if (trig_i.valid) begin
        for (int c = 0; c < disc_pkg::CHANNELS; c++) begin
          hist_q[c] <= hist_w[c][HIST_LEN-2:0];
        end
        if (!primed) begin
          fill_q <= fill_q + 1'b1;
        end else begin
          idx_q       <= idx_q + 1'b1;
          prev_keep_q <= keep;
        end
      end
    end
  end

  // sample payload
  always_ff @(posedge adc_clk) begin
    if (trig_i.valid) begin
      for (int c = 0; c < disc_pkg::CHANNELS; c++) begin
        sd_q[c] <= {sd_q[c][disc_pkg::MAX_DELAY-2:0], trig_i.data[c]};
      end
    end
    if (step) begin
      for (int c = 0; c < disc_pkg::CHANNELS; c++) begin
        out_data_q[c] <= sd_q[c][disc_pkg::MAX_DELAY-1];
        ts_idx_q[c]   <= idx_q;
      end
    end
  end

  assign samples_o.valid = out_valid_q;
  assign samples_o.data  = out_data_q;
  assign tstamps_o.valid = ts_valid_q;
  assign tstamps_o.index = ts_idx_q;

  // a timestamp always rides along with the first kept sample
  a_tstamp_with_sample : assert property (@(posedge adc_clk) disable iff (reset_i)
    (tstamps_o.valid & ~samples_o.valid) == '0);

endmodule

// ==== design/disc_trigger_detect.sv ====
////////////////////////////////////////////////////////////
// per-channel hysteresis comparators and trigger selection;
// trig_o carries each sample with its trigger one cycle later
////////////////////////////////////////////////////////////
module disc_trigger_detect (
  input  logic                                  adc_clk,
  input  logic                                  reset_i,
  input  logic                                  state_clear_i,
  input  disc_pkg::disc_cfg_t                   cfg_i,
  input  disc_pkg::sample_bus_t                 samples_i,
  input  logic [disc_pkg::DIGITAL_INPUTS-1:0]   digital_trig_i,
  output disc_pkg::trig_bus_t                   trig_o
);

  logic [disc_pkg::CHANNELS-1:0]                            state_q;
  logic [disc_pkg::CHANNELS-1:0]                            state_d;
  // analog states in the low bits, digital inputs above them
  logic [disc_pkg::DIGITAL_INPUTS+disc_pkg::CHANNELS-1:0]   sources;
  logic [disc_pkg::CHANNELS-1:0]                            trig_sel;
  logic                                                     valid_q;
  logic [disc_pkg::CHANNELS-1:0][disc_pkg::SAMPLE_WIDTH-1:0] data_q;
  logic [disc_pkg::CHANNELS-1:0]                            trig_q;

  ////////////////////////////////////////////////////////////
  // hysteresis
  ////////////////////////////////////////////////////////////
  // a clear drops the old state, a sample on the same cycle
  // is applied on top of the cleared state
  always_comb begin
    for (int k = 0; k < disc_pkg::CHANNELS; k++) begin
      state_d[k] = state_clear_i ? 1'b0 : state_q[k];
      if (samples_i.valid) begin
        if ($signed(samples_i.data[k]) > $signed(cfg_i.high_th[k])) begin
          state_d[k] = 1'b1;
        end else if ($signed(samples_i.data[k]) < $signed(cfg_i.low_th[k])) begin
          state_d[k] = 1'b0;
        end
      end
    end
  end

  // source codes 0..1 pick an analog state, 2..3 a digital input
  assign sources = {digital_trig_i, state_d};

  always_comb begin
    for (int k = 0; k < disc_pkg::CHANNELS; k++) begin
      trig_sel[k] = sources[cfg_i.src[k]];
    end
  end

  ////////////////////////////////////////////////////////////
  // output stage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      state_q <= '0;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      valid_q <= samples_i.valid;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (samples_i.valid) begin
      data_q <= samples_i.data;
      trig_q <= trig_sel;
    end
  end

  assign trig_o.valid = valid_q;
  assign trig_o.data  = data_q;
  assign trig_o.trig  = trig_q;

  // every input sample shows up on trig_o exactly one cycle later
  a_valid_latency : assert property (@(posedge adc_clk) disable iff (reset_i)
    samples_i.valid |=> trig_o.valid);
  a_no_extra_valid : assert property (@(posedge adc_clk) disable iff (reset_i)
    !samples_i.valid |=> !trig_o.valid);

endmodule

// ==== design/disc_cfg_regs.sv ====
////////////////////////////////////////////////////////////
// AXI4-Lite slave with the discriminator configuration;
// register values drive cfg_o the cycle after a write
////////////////////////////////////////////////////////////
module disc_cfg_regs (
  input  logic                adc_clk,
  input  logic                reset_i,
  input  disc_pkg::axil_req_t axil_req_i,
  output disc_pkg::axil_rsp_t axil_rsp_o,
  output disc_pkg::disc_cfg_t cfg_o
);

  logic                                 wr_hs;
  logic                                 rd_hs;
  disc_pkg::disc_cfg_t                  cfg_q;
  logic                                 bvalid_q;
  logic                                 rvalid_q;
  disc_pkg::axil_resp_e                 bresp_q;
  disc_pkg::axil_resp_e                 rresp_q;
  logic [disc_pkg::AXIL_DATA_WIDTH-1:0] rdata_q;
  logic [disc_pkg::AXIL_DATA_WIDTH-1:0] rdata_d;

  function automatic logic is_mapped(input logic [disc_pkg::AXIL_ADDR_WIDTH-1:0] addr);
    case (disc_pkg::reg_addr_e'(addr))
      disc_pkg::THRESH0, disc_pkg::THRESH1,
      disc_pkg::DELAY0, disc_pkg::DELAY1,
      disc_pkg::SRC, disc_pkg::DISABLE: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // address and data must arrive together, one response outstanding
  assign wr_hs = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
  assign rd_hs = axil_req_i.arvalid && !rvalid_q;

  ////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////
  always_comb begin
    rdata_d = '0;
    case (disc_pkg::reg_addr_e'(axil_req_i.araddr))
      disc_pkg::THRESH0: rdata_d = {cfg_q.high_th[0], cfg_q.low_th[0]};
      disc_pkg::THRESH1: rdata_d = {cfg_q.high_th[1], cfg_q.low_th[1]};
      disc_pkg::DELAY0: begin
        rdata_d[2*disc_pkg::DELAY_BITS-1:0] = {cfg_q.stop_dly[0], cfg_q.start_dly[0]};
      end
      disc_pkg::DELAY1: begin
        rdata_d[2*disc_pkg::DELAY_BITS-1:0] = {cfg_q.stop_dly[1], cfg_q.start_dly[1]};
      end
      disc_pkg::SRC: rdata_d[disc_pkg::CHANNELS*disc_pkg::SRC_BITS-1:0] = cfg_q.src;
      disc_pkg::DISABLE: rdata_d[disc_pkg::CHANNELS-1:0] = cfg_q.disable_ch;
      default: rdata_d = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // registers and handshake state
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      cfg_q    <= '0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_hs) begin
        bvalid_q <= 1'b1;
        case (disc_pkg::reg_addr_e'(axil_req_i.awaddr))
          disc_pkg::THRESH0: begin
            cfg_q.high_th[0] <= axil_req_i.wdata[31:16];
            cfg_q.low_th[0]  <= axil_req_i.wdata[15:0];
          end
          disc_pkg::THRESH1: begin
            cfg_q.high_th[1] <= axil_req_i.wdata[31:16];
            cfg_q.low_th[1]  <= axil_req_i.wdata[15:0];
          end
          disc_pkg::DELAY0: begin
            cfg_q.stop_dly[0]  <= axil_req_i.wdata[7:4];
            cfg_q.start_dly[0] <= axil_req_i.wdata[3:0];
          end
          disc_pkg::DELAY1: begin
            cfg_q.stop_dly[1]  <= axil_req_i.wdata[7:4];
            cfg_q.start_dly[1] <= axil_req_i.wdata[3:0];
          end
          disc_pkg::SRC: begin
            cfg_q.src <= axil_req_i.wdata[disc_pkg::CHANNELS*disc_pkg::SRC_BITS-1:0];
          end
          disc_pkg::DISABLE: cfg_q.disable_ch <= axil_req_i.wdata[disc_pkg::CHANNELS-1:0];
          // unmapped, nothing changes
          default: ;
        endcase
      end else if (axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end

      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end else if (axil_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // response payload
  always_ff @(posedge adc_clk) begin
    if (wr_hs) begin
      bresp_q <= is_mapped(axil_req_i.awaddr) ? disc_pkg::OKAY : disc_pkg::SLVERR;
    end
    if (rd_hs) begin
      rdata_q <= rdata_d;
      rresp_q <= is_mapped(axil_req_i.araddr) ? disc_pkg::OKAY : disc_pkg::SLVERR;
    end
  end

  assign axil_rsp_o.awready = wr_hs;
  assign axil_rsp_o.wready  = wr_hs;
  assign axil_rsp_o.bvalid  = bvalid_q;
  assign axil_rsp_o.bresp   = bresp_q;
  assign axil_rsp_o.arready = rd_hs;
  assign axil_rsp_o.rvalid  = rvalid_q;
  assign axil_rsp_o.rdata   = rdata_q;
  assign axil_rsp_o.rresp   = rresp_q;
  assign cfg_o              = cfg_q;

  // responses hold until the master takes them
  a_bvalid_hold : assert property (@(posedge adc_clk) disable iff (reset_i)
    bvalid_q && !axil_req_i.bready |=> bvalid_q);
  a_rvalid_hold : assert property (@(posedge adc_clk) disable iff (reset_i)
    rvalid_q && !axil_req_i.rready |=> rvalid_q && $stable(rdata_q));

endmodule

// ==== design/disc_pkg.sv ====
////////////////////////////////////////////////////////////
// sizes, register map, enums and bus structs shared by the
// sample discriminator RTL and its testbench
////////////////////////////////////////////////////////////
package disc_pkg;

  // datapath sizes
  localparam int CHANNELS        = 2;
  localparam int DIGITAL_INPUTS  = 2;
  localparam int SAMPLE_WIDTH    = 16;
  localparam int MAX_DELAY       = 16;
  localparam int DELAY_BITS      = 4;
  localparam int SRC_BITS        = 2;
  localparam int TSTAMP_WIDTH    = 32;

  // configuration bus
  localparam int AXIL_ADDR_WIDTH = 8;
  localparam int AXIL_DATA_WIDTH = 32;

  ////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////
  typedef enum logic [AXIL_ADDR_WIDTH-1:0] {
    THRESH0 = 8'h00,
    THRESH1 = 8'h04,
    DELAY0  = 8'h08,
    DELAY1  = 8'h0C,
    SRC     = 8'h10,
    DISABLE = 8'h14
  } reg_addr_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  ////////////////////////////////////////////////////////////
  // buses
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic                       awvalid;
    logic [AXIL_ADDR_WIDTH-1:0] awaddr;
    logic                       wvalid;
    logic [AXIL_DATA_WIDTH-1:0] wdata;
    logic                       bready;
    logic                       arvalid;
    logic [AXIL_ADDR_WIDTH-1:0] araddr;
    logic                       rready;
  } axil_req_t;

  typedef struct packed {
    logic                       awready;
    logic                       wready;
    logic                       bvalid;
    axil_resp_e                 bresp;
    logic                       arready;
    logic                       rvalid;
    logic [AXIL_DATA_WIDTH-1:0] rdata;
    axil_resp_e                 rresp;
  } axil_rsp_t;

  // thresholds are two's complement, compared signed
  typedef struct packed {
    logic [CHANNELS-1:0][SAMPLE_WIDTH-1:0] low_th;
    logic [CHANNELS-1:0][SAMPLE_WIDTH-1:0] high_th;
    logic [CHANNELS-1:0][DELAY_BITS-1:0]   start_dly;
    logic [CHANNELS-1:0][DELAY_BITS-1:0]   stop_dly;
    logic [CHANNELS-1:0][SRC_BITS-1:0]     src;
    logic [CHANNELS-1:0]                   disable_ch;
  } disc_cfg_t;

  typedef struct packed {
    logic                                  valid;
    logic [CHANNELS-1:0][SAMPLE_WIDTH-1:0] data;
  } sample_bus_t;

  // samples after the detect stage, one selected trigger per channel
  typedef struct packed {
    logic                                  valid;
    logic [CHANNELS-1:0][SAMPLE_WIDTH-1:0] data;
    logic [CHANNELS-1:0]                   trig;
  } trig_bus_t;

  typedef struct packed {
    logic [CHANNELS-1:0]                   valid;
    logic [CHANNELS-1:0][SAMPLE_WIDTH-1:0] data;
  } out_bus_t;

  typedef struct packed {
    logic [CHANNELS-1:0]                   valid;
    logic [CHANNELS-1:0][TSTAMP_WIDTH-1:0] index;
  } tstamp_bus_t;

endpackage
